// File: logic/aes_key_defines.svh
`ifndef AES_KEY_DEFINES_SVH
`define AES_KEY_DEFINES_SVH

// geometry of the AES-128 key schedule

// rounds produced by expansion
// the cipher key itself is stored on top of these as round 0
`define AES_ROUNDS 10

// bytes in one round key made of four words of four bytes
`define AES_KEY_BYTES 16

// bytes per key word as the unit that RotWord and SubWord act on
// the first word of each round key is the only one that passes the S-box
`define AES_WORD_BYTES 4

// key bytes arrive and leave in FIPS-197 order
// so byte 0 of a round key is the first byte on the wire
// and byte 15 is the last byte of the last word

`endif

// File: logic/aes_field_pkg.sv
`default_nettype none

package aes_field_pkg;

    // one element of GF(2^8) reduced by x^8 + x^4 + x^3 + x + 1
    typedef logic [7:0] byte_t;

    // forward S-box in row order, entry 0 is the leftmost byte
    // so indexing the packed array with the input byte gives the output directly
    localparam byte_t [0:255] SBOX_TABLE = {
        256'h637c777bf26b6fc53001672bfed7ab76ca82c97dfa5947f0add4a2af9ca472c0,
        256'hb7fd9326363ff7cc34a5e5f171d8311504c723c31896059a071280e2eb27b275,
        256'h09832c1a1b6e5aa0523bd6b329e32f8453d100ed20fcb15b6acbbe394a4c58cf,
        256'hd0efaafb434d338545f9027f503c9fa851a3408f929d38f5bcb6da2110fff3d2,
        256'hcd0c13ec5f974417c4a77e3d645d197360814fdc222a908846eeb814de5e0bdb,
        256'he0323a0a4906245cc2d3ac629195e479e7c8376d8dd54ea96c56f4ea657aae08,
        256'hba78252e1ca6b4c6e8dd741f4bbd8b8a703eb5664803f60e613557b986c11d9e,
        256'he1f8981169d98e949b1e87e9ce5528df8ca1890dbfe6426841992d0fb054bb16
    };

    // SubBytes on a single byte
    // the table is a constant so synthesis folds this into a 256 by 8 ROM
    // in the expander this feeds SubWord one byte at a time
    function automatic byte_t sbox(input byte_t a);
        return SBOX_TABLE[a];
    endfunction

    // multiply by x in the field
    // a carry out of bit 7 is folded back in with the low part of the polynomial
    // repeated application walks the round constants 01 02 04 .. 80 1b 36
    function automatic byte_t xtime(input byte_t a);
        byte_t shifted;
        shifted = {a[6:0], 1'b0};  // plain left shift, drops bit 7
        if (a[7]) begin
            shifted = shifted ^ 8'h1b;  // reduce modulo the AES polynomial
        end
        return shifted;
    endfunction

endpackage

`default_nettype wire

// File: logic/key_sched_pkg.sv
`default_nettype none

`include "aes_key_defines.svh"

package key_sched_pkg;

    // round 0 holds the cipher key and rounds 1 to 10 the expanded keys
    typedef logic [$clog2(`AES_ROUNDS + 1)-1:0] round_t;

    // position of a byte inside one round key
    // 0 is the first key byte in FIPS-197 order
    typedef logic [$clog2(`AES_KEY_BYTES)-1:0] byte_idx_t;

    // states of the byte-serial expander
    typedef enum logic [1:0] {
        idle,    // nothing loaded since reset
        load,    // collecting the 16 cipher key bytes
        expand,  // producing rounds 1 to 10 one byte per cycle
        ready    // every round key is in the store
    } expand_state_t;

endpackage

`default_nettype wire

// File: logic/key_expand_byte.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_defines.svh"

module key_expand_byte (
    input  logic                     clk,
    input  logic                     rst,
    input  aes_field_pkg::byte_t     key_byte,
    input  logic                     key_valid,
    input  logic                     key_first,
    output logic                     wr_en,
    output key_sched_pkg::round_t    wr_round,
    output key_sched_pkg::byte_idx_t wr_idx,
    output aes_field_pkg::byte_t     wr_data,
    output logic                     keys_ready
);

    // the shift register moves one byte towards index 0 per step
    // so at byte k of a round, slot 0 holds old byte k and slot 16-k holds new byte 0
    localparam int LAST_BYTE     = `AES_KEY_BYTES - 1;
    localparam int PREV_WORD_TAP = `AES_KEY_BYTES - `AES_WORD_BYTES;  // new byte k-4 sits here
    localparam int ROT_TAP       = PREV_WORD_TAP + 1;                 // old bytes 13 to 15 for k < 3
    localparam int WRAP_TAP      = PREV_WORD_TAP - `AES_WORD_BYTES + 1;  // old byte 12 at k == 3

    key_sched_pkg::expand_state_t state;
    key_sched_pkg::byte_idx_t     byte_cnt;   // byte position in the current key or round
    key_sched_pkg::round_t        round_cnt;  // round being produced while expanding
    aes_field_pkg::byte_t         rcon;       // round constant of the current round
    aes_field_pkg::byte_t         key_sr [`AES_KEY_BYTES];  // previous round key with the oldest byte at 0

    logic                         restart;      // key_first strobe seen this cycle
    logic                         load_accept;  // a key byte is taken this cycle
    logic                         expand_step;  // one expansion byte is produced this cycle
    logic                         shift_en;
    key_sched_pkg::byte_idx_t     load_idx;     // where the incoming key byte lands
    aes_field_pkg::byte_t         rot_byte;     // byte of RotWord(last word) for this position
    aes_field_pkg::byte_t         sub_byte;
    aes_field_pkg::byte_t         new_byte;     // next round key byte
    aes_field_pkg::byte_t         shift_in;

    // key_first always wins, even halfway through a load or an expansion
    assign restart     = key_valid && key_first;
    assign load_accept = key_valid && (key_first || state == key_sched_pkg::load);
    assign expand_step = (state == key_sched_pkg::expand) && !restart;
    assign shift_en    = load_accept || expand_step;
    assign load_idx    = key_first ? '0 : byte_cnt;

    // RotWord picks old bytes 13, 14, 15 and then 12
    // the first three all pass through slot ROT_TAP as the register shifts
    assign rot_byte = (byte_cnt == key_sched_pkg::byte_idx_t'(`AES_WORD_BYTES - 1))
                    ? key_sr[WRAP_TAP]
                    : key_sr[ROT_TAP];
    assign sub_byte = aes_field_pkg::sbox(rot_byte);  // one S-box serves the whole word

    always_comb begin
        if (byte_cnt < key_sched_pkg::byte_idx_t'(`AES_WORD_BYTES)) begin
            new_byte = key_sr[0] ^ sub_byte;  // first word mixes in SubWord(RotWord(w3))
            if (byte_cnt == '0) begin
                new_byte = new_byte ^ rcon;  // only the leading byte carries the constant
            end
        end else begin
            // later words chain on the new word before them
            new_byte = key_sr[0] ^ key_sr[PREV_WORD_TAP];
        end
    end

    assign shift_in = load_accept ? key_byte : new_byte;  // key bytes enter the same way

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= key_sched_pkg::idle;
            byte_cnt   <= '0;
            round_cnt  <= '0;
            rcon       <= 8'h01;
            wr_en      <= 1'b0;
            keys_ready <= 1'b0;
        end else begin
            wr_en      <= shift_en;  // every shifted byte is also written to the store
            // ready shows one cycle after the state so the last write has landed
            keys_ready <= !restart && (state == key_sched_pkg::ready);

            if (load_accept) begin
                if (load_idx == key_sched_pkg::byte_idx_t'(LAST_BYTE)) begin
                    state     <= key_sched_pkg::expand;  // full key in the register
                    byte_cnt  <= '0;
                    round_cnt <= key_sched_pkg::round_t'(1);
                    rcon      <= 8'h01;
                end else begin
                    state    <= key_sched_pkg::load;
                    byte_cnt <= load_idx + 1'b1;
                end
            end else if (expand_step) begin
                byte_cnt <= byte_cnt + 1'b1;  // wraps to 0 at the end of a round
                if (byte_cnt == key_sched_pkg::byte_idx_t'(LAST_BYTE)) begin
                    if (round_cnt == key_sched_pkg::round_t'(`AES_ROUNDS)) begin
                        state <= key_sched_pkg::ready;
                    end else begin
                        round_cnt <= round_cnt + 1'b1;
                        rcon      <= aes_field_pkg::xtime(rcon);  // next constant in the chain
                    end
                end
            end
        end
    end

    // the register and the write port advance together on every shifted byte
    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int i = 0; i < LAST_BYTE; i++) begin
                key_sr[i] <= key_sr[i + 1];
            end
            key_sr[LAST_BYTE] <= shift_in;
            wr_round <= load_accept ? '0 : round_cnt;     // the cipher key is round 0
            wr_idx   <= load_accept ? load_idx : byte_cnt;
            wr_data  <= shift_in;
        end
    end

endmodule

`default_nettype wire

// File: logic/round_key_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_defines.svh"

module round_key_store (
    input  logic                     clk,
    input  logic                     wr_en,
    input  key_sched_pkg::round_t    wr_round,
    input  key_sched_pkg::byte_idx_t wr_idx,
    input  aes_field_pkg::byte_t     wr_data,
    input  key_sched_pkg::round_t    rd_round,
    input  key_sched_pkg::byte_idx_t rd_idx,
    output aes_field_pkg::byte_t     rd_data
);

    // cipher key plus ten expanded keys, 176 bytes in all
    localparam int DEPTH  = (`AES_ROUNDS + 1) * `AES_KEY_BYTES;
    localparam int ADDR_W = $clog2(DEPTH);

    aes_field_pkg::byte_t mem [DEPTH];  // round major, byte minor
    logic [ADDR_W-1:0]    wr_addr;
    logic [ADDR_W-1:0]    rd_addr;

    // flat address is round times key bytes plus the byte index
    // the widest round index still fits in ADDR_W so nothing wraps here
    assign wr_addr = ADDR_W'(wr_round) * ADDR_W'(`AES_KEY_BYTES) + ADDR_W'(wr_idx);
    assign rd_addr = ADDR_W'(rd_round) * ADDR_W'(`AES_KEY_BYTES) + ADDR_W'(rd_idx);

    // single write port driven by the expander
    always_ff @(posedge clk) begin
        if (wr_en && wr_addr < ADDR_W'(DEPTH)) begin  // rounds above 10 have no storage
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read gives the data one cycle after the address
    // an address past the last round reads as zero rather than garbage
    always_ff @(posedge clk) begin
        if (rd_addr < ADDR_W'(DEPTH)) begin
            rd_data <= mem[rd_addr];
        end else begin
            rd_data <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/add_round_key.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_defines.svh"

module add_round_key (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     keys_ready,
    input  aes_field_pkg::byte_t     ark_data,
    input  logic                     ark_valid,
    input  logic                     ark_first,
    input  key_sched_pkg::round_t    ark_round,
    output key_sched_pkg::round_t    rd_round,
    output key_sched_pkg::byte_idx_t rd_idx,
    input  aes_field_pkg::byte_t     rd_data,
    output aes_field_pkg::byte_t     ark_out,
    output logic                     ark_out_valid
);

    localparam int LAST_BYTE = `AES_KEY_BYTES - 1;

    key_sched_pkg::byte_idx_t byte_cnt;   // position of the next byte in the block
    key_sched_pkg::round_t    cur_round;  // round latched at the start of the block
    logic                     accept;     // data byte taken this cycle
    aes_field_pkg::byte_t     data_d;     // data waiting for its key byte
    logic                     valid_d;

    // without a complete schedule the store holds nothing useful so bytes are dropped
    assign accept = ark_valid && keys_ready;

    // stage one issues the read straight from the inputs
    // ark_first overrides the counter and the latched round in the same cycle
    assign rd_round = ark_first ? ark_round : cur_round;
    assign rd_idx   = ark_first ? '0 : byte_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt      <= '0;
            cur_round     <= '0;
            valid_d       <= 1'b0;
            ark_out_valid <= 1'b0;
        end else begin
            valid_d       <= accept;   // stage one valid
            ark_out_valid <= valid_d;  // stage two valid two cycles after the strobe
            if (accept) begin
                cur_round <= rd_round;  // equal to cur_round unless ark_first was set
                if (rd_idx == key_sched_pkg::byte_idx_t'(LAST_BYTE)) begin
                    byte_cnt <= '0;  // a new block may follow without ark_first
                end else begin
                    byte_cnt <= rd_idx + 1'b1;
                end
            end
        end
    end

    // data byte and key byte meet in stage two
    always_ff @(posedge clk) begin
        data_d  <= ark_data;           // lines up with rd_data on the next cycle
        ark_out <= data_d ^ rd_data;   // AddRoundKey for one byte
    end

endmodule

`default_nettype wire

// File: logic/key_schedule_top.sv
`timescale 1ns/1ps
`default_nettype none

module key_schedule_top (
    input  logic                  clk,
    input  logic                  rst,
    input  aes_field_pkg::byte_t  key_byte,
    input  logic                  key_valid,
    input  logic                  key_first,
    output logic                  keys_ready,
    input  aes_field_pkg::byte_t  ark_data,
    input  logic                  ark_valid,
    input  logic                  ark_first,
    input  key_sched_pkg::round_t ark_round,
    output aes_field_pkg::byte_t  ark_out,
    output logic                  ark_out_valid
);

    // write side, expander into the store
    logic                     wr_en;
    key_sched_pkg::round_t    wr_round;
    key_sched_pkg::byte_idx_t wr_idx;
    aes_field_pkg::byte_t     wr_data;

    // read side, AddRoundKey against the store
    key_sched_pkg::round_t    rd_round;
    key_sched_pkg::byte_idx_t rd_idx;
    aes_field_pkg::byte_t     rd_data;

    key_expand_byte u_expand (
        .clk        (clk),
        .rst        (rst),
        .key_byte   (key_byte),
        .key_valid  (key_valid),
        .key_first  (key_first),
        .wr_en      (wr_en),
        .wr_round   (wr_round),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .keys_ready (keys_ready)  // also gates the consumer
    );

    round_key_store u_store (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_round (wr_round),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .rd_round (rd_round),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

    add_round_key u_ark (
        .clk           (clk),
        .rst           (rst),
        .keys_ready    (keys_ready),
        .ark_data      (ark_data),
        .ark_valid     (ark_valid),
        .ark_first     (ark_first),
        .ark_round     (ark_round),
        .rd_round      (rd_round),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .ark_out       (ark_out),
        .ark_out_valid (ark_out_valid)
    );

endmodule

`default_nettype wire

// File: sim/aes_key_model.svh
`ifndef AES_KEY_MODEL_SVH
`define AES_KEY_MODEL_SVH

// reference schedule, round major and byte minor like the store in the DUT
aes_field_pkg::byte_t ref_keys [(`AES_ROUNDS + 1) * `AES_KEY_BYTES];

// shift-and-add multiply in GF(2^8), reducing by 0x11b at every step
function automatic aes_field_pkg::byte_t mul_gf(input aes_field_pkg::byte_t a,
                                                input aes_field_pkg::byte_t b);
    aes_field_pkg::byte_t acc;
    aes_field_pkg::byte_t p;
    acc = '0;
    p   = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            acc = acc ^ p;
        end
        p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1b : 8'h00);
    end
    return acc;
endfunction

// multiplicative inverse by search, zero maps to zero as AES defines it
function automatic aes_field_pkg::byte_t invert(input aes_field_pkg::byte_t a);
    for (int c = 1; c < 256; c++) begin
        if (mul_gf(a, 8'(c)) == 8'h01) begin
            return 8'(c);
        end
    end
    return 8'h00;
endfunction

// S-box as inverse followed by the affine map, b ^ rotl 1..4 ^ 0x63
function automatic aes_field_pkg::byte_t sub_byte_ref(input aes_field_pkg::byte_t a);
    aes_field_pkg::byte_t b;
    b = invert(a);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
endfunction

function automatic logic [31:0] sub_word(input logic [31:0] w);
    return {sub_byte_ref(w[31:24]), sub_byte_ref(w[23:16]),
            sub_byte_ref(w[15:8]), sub_byte_ref(w[7:0])};
endfunction

// FIPS-197 expansion on whole 32-bit words, then flattened into ref_keys
task automatic expand_reference(input logic [127:0] key);
    localparam int NK = `AES_KEY_BYTES / `AES_WORD_BYTES;  // words per round key
    logic [31:0]          w [NK * (`AES_ROUNDS + 1)];
    logic [31:0]          temp;
    aes_field_pkg::byte_t rc;
    rc = 8'h01;
    for (int i = 0; i < NK; i++) begin
        w[i] = key[127 - 32 * i -: 32];  // w0 holds the first four key bytes
    end
    for (int i = NK; i < NK * (`AES_ROUNDS + 1); i++) begin
        temp = w[i - 1];
        if (i % NK == 0) begin
            temp = sub_word({temp[23:0], temp[31:24]}) ^ {rc, 24'h0};  // RotWord then SubWord
            rc   = mul_gf(rc, 8'h02);
        end
        w[i] = w[i - NK] ^ temp;
    end
    for (int i = 0; i < NK * (`AES_ROUNDS + 1); i++) begin
        for (int j = 0; j < `AES_WORD_BYTES; j++) begin
            ref_keys[`AES_WORD_BYTES * i + j] = w[i][31 - 8 * j -: 8];
        end
    end
endtask

// one round key as 128 bits, byte 0 in the top byte
function automatic logic [127:0] ref_round_key(input int r);
    logic [127:0] rk;
    rk = '0;
    for (int i = 0; i < `AES_KEY_BYTES; i++) begin
        rk = {rk[119:0], ref_keys[r * `AES_KEY_BYTES + i]};
    end
    return rk;
endfunction

`endif

// File: sim/key_schedule_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_defines.svh"

module key_schedule_tb;

    localparam int CLK_PERIOD    = 100;
    localparam int EXPAND_CYCLES = `AES_ROUNDS * `AES_KEY_BYTES;  // 160 byte steps
    localparam int READY_LIMIT   = EXPAND_CYCLES + 8;              // small margin on top
    localparam int ARK_LATENCY   = 2;
    localparam int DRAIN_LIMIT   = 8;

    logic clk;
    logic rst;
    aes_field_pkg::byte_t  key_byte;
    logic                  key_valid;
    logic                  key_first;
    logic                  keys_ready;
    aes_field_pkg::byte_t  ark_data;
    logic                  ark_valid;
    logic                  ark_first;
    key_sched_pkg::round_t ark_round;
    aes_field_pkg::byte_t  ark_out;
    logic                  ark_out_valid;

    int cyc = 0;  // counts rising edges, read 1 ns after the edge and at the falling edge
    int checks = 0;
    int value_errors = 0;
    int other_errors = 0;
    aes_field_pkg::byte_t exp_q [$];  // expected outputs in order
    int                   due_q [$];  // cycle on which each one must show

    `include "aes_key_model.svh"

    key_schedule_top UUT (
        .clk (clk), .rst (rst),
        .key_byte (key_byte), .key_valid (key_valid), .key_first (key_first),
        .keys_ready (keys_ready),
        .ark_data (ark_data), .ark_valid (ark_valid), .ark_first (ark_first),
        .ark_round (ark_round), .ark_out (ark_out), .ark_out_valid (ark_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_byte(input string name, input aes_field_pkg::byte_t actual,
                              input aes_field_pkg::byte_t expected);
        checks++;
        if (actual !== expected) begin
            $display("error: %s is 0x%02h, expected 0x%02h at cycle %0d", name, actual, expected, cyc);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h at cycle %0d", name, actual, expected, cyc);
            value_errors++;
        end
    endtask

    // outputs are stable at the falling edge, and valid must match the due cycle exactly
    always @(negedge clk) begin : out_monitor
        logic due;
        if (!rst) begin
            due = (due_q.size() > 0) && (due_q[0] == cyc);
            check_flag("ark_out_valid", ark_out_valid, due);  // also catches dropped bytes
            if (due) begin
                if (ark_out_valid) check_byte("ark_out", ark_out, exp_q[0]);
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;  // inputs change just after the edge
    endtask

    task automatic strobe_key_byte(input aes_field_pkg::byte_t b, input logic first);
        key_byte  = b;
        key_valid = 1'b1;
        key_first = first;
        next_cycle();
        key_valid = 1'b0;
        key_first = 1'b0;
    endtask

    // bytes go in FIPS-197 order, with random idle cycles up to max_gap between strobes
    task automatic load_key(input logic [127:0] key, input int max_gap);
        expand_reference(key);
        for (int i = 0; i < `AES_KEY_BYTES; i++) begin
            strobe_key_byte(key[127 - 8 * i -: 8], i == 0);
            repeat ($urandom % (max_gap + 1)) next_cycle();
        end
    endtask

    task automatic wait_ready(output int waited);
        waited = 0;
        while (keys_ready !== 1'b1 && waited < READY_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (keys_ready !== 1'b1) begin
            $display("error: keys_ready did not rise within %0d cycles", READY_LIMIT);
            other_errors++;
        end
    endtask

    // one 16-byte block, expect_out says whether the DUT should answer it
    task automatic send_block(input key_sched_pkg::round_t round, input logic [127:0] data,
                              input logic [127:0] key, input logic expect_out);
        aes_field_pkg::byte_t d;
        for (int i = 0; i < `AES_KEY_BYTES; i++) begin
            d         = data[127 - 8 * i -: 8];
            ark_data  = d;
            ark_valid = 1'b1;
            ark_first = (i == 0);
            // round is only sampled with ark_first so the rest get noise
            ark_round = (i == 0) ? round : key_sched_pkg::round_t'($urandom % 11);
            if (expect_out) begin
                exp_q.push_back(d ^ key[127 - 8 * i -: 8]);
                due_q.push_back(cyc + ARK_LATENCY);
            end
            next_cycle();
        end
        ark_valid = 1'b0;
        ark_first = 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("error: %0d outputs never arrived", exp_q.size());
            other_errors++;
            exp_q.delete();
            due_q.delete();
        end
    endtask

    task automatic stream_all_rounds();
        for (int r = 0; r <= `AES_ROUNDS; r++) begin
            send_block(key_sched_pkg::round_t'(r), '0, ref_round_key(r), 1'b1);
        end
        drain_outputs();
    endtask

    task automatic known_vector_test();
        int waited;
        load_key(128'h2b7e151628aed2a6abf7158809cf4f3c, 3);
        wait_ready(waited);
        send_block(4'd10, '0, 128'hd014f9a8c9ee2589e13f0cc8b6630ca6, 1'b1);  // published round 10
        drain_outputs();
    endtask

    task automatic random_key_rounds();
        int waited;
        repeat (3) begin
            load_key({$urandom, $urandom, $urandom, $urandom}, 1);
            wait_ready(waited);
            stream_all_rounds();  // zero data returns the key bytes themselves
        end
    endtask

    task automatic xor_random_blocks();
        key_sched_pkg::round_t r;
        repeat (6) begin
            r = key_sched_pkg::round_t'($urandom % 11);
            send_block(r, {$urandom, $urandom, $urandom, $urandom}, ref_round_key(int'(r)), 1'b1);
            repeat ($urandom % 3) next_cycle();
        end
        drain_outputs();
    endtask

    task automatic ready_and_drop_rules();
        logic [127:0] key;
        int           waited;
        key = {$urandom, $urandom, $urandom, $urandom};
        strobe_key_byte(key[127:120], 1'b1);
        check_flag("keys_ready", keys_ready, 1'b0);  // reload clears ready at once
        send_block(4'd1, {4{$urandom}}, '0, 1'b0);  // mid-load data must vanish
        for (int i = 1; i < `AES_KEY_BYTES; i++) begin
            strobe_key_byte(key[127 - 8 * i -: 8], 1'b0);
        end
        expand_reference(key);
        send_block(4'd5, {4{$urandom}}, '0, 1'b0);  // dropped during expansion too
        wait_ready(waited);
        if (waited + `AES_KEY_BYTES < EXPAND_CYCLES) begin
            $display("error: keys_ready rose after %0d cycles, before expansion could finish",
                     waited + `AES_KEY_BYTES);
            other_errors++;
        end
        send_block(4'd5, {4{$urandom}}, ref_round_key(5), 1'b1);
        drain_outputs();
    endtask

    task automatic back_to_back_blocks();
        int r;
        for (int i = 0; i < 5; i++) begin
            r = (i * 7 + 3) % 11;  // 3 10 6 2 9, no idle cycle between blocks
            send_block(key_sched_pkg::round_t'(r), {$urandom, $urandom, $urandom, $urandom},
                       ref_round_key(r), 1'b1);
        end
        drain_outputs();
    endtask

    task automatic reload_mid_expansion();
        int waited;
        load_key({$urandom, $urandom, $urandom, $urandom}, 0);
        repeat (EXPAND_CYCLES / 2) begin
            next_cycle();
            check_flag("keys_ready", keys_ready, 1'b0);
        end
        load_key({$urandom, $urandom, $urandom, $urandom}, 0);  // model now holds key two
        wait_ready(waited);
        stream_all_rounds();
    endtask

    initial begin
        void'($urandom(70594));
        rst       = 1'b1;
        key_byte  = '0;
        key_valid = 1'b0;
        key_first = 1'b0;
        ark_data  = '0;
        ark_valid = 1'b0;
        ark_first = 1'b0;
        ark_round = '0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        check_flag("keys_ready", keys_ready, 1'b0);  // nothing loaded yet

        known_vector_test();
        random_key_rounds();
        xor_random_blocks();
        ready_and_drop_rules();
        back_to_back_blocks();
        reload_mid_expansion();

        $display("summary: %0d checks, %0d value errors, %0d other errors",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: key_schedule.f
+incdir+logic
+incdir+sim
logic/aes_field_pkg.sv
logic/key_sched_pkg.sv
logic/key_expand_byte.sv
logic/round_key_store.sv
logic/add_round_key.sv
logic/key_schedule_top.sv
sim/key_schedule_tb.sv

// File: Makefile
# Verilator build and run of the key schedule testbench

VERILATOR ?= verilator
TOP       ?= key_schedule_tb
FILELIST  ?= key_schedule.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(wildcard logic/*.sv logic/*.svh sim/*.sv sim/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
